/* timer_pkg.sv */
package timer_pkg;

    // ----------------------------------------------------------------------
    // timebase
    // ----------------------------------------------------------------------

    localparam int TIMER_WIDTH = 64;

    typedef logic [TIMER_WIDTH-1:0] time_t;

    // cycles between sync triggers
    localparam logic [15:0] SYNC_PERIOD = 16'd200;

    // ----------------------------------------------------------------------
    // ring geometry
    // ----------------------------------------------------------------------

    localparam int NODES = 4;       // relay nodes between master out and in

    // hop count field, one per node passed
    localparam int HOP_WIDTH = 8;

endpackage

/* ring_pkg.sv */
package ring_pkg;

    // byte position within a frame
    typedef logic [3:0] pos_t;

    localparam int FRAME_LEN = 11;

    // ----------------------------------------------------------------------
    // frame byte layout
    // ----------------------------------------------------------------------

    localparam pos_t POS_OP   = 4'd0;
    localparam pos_t POS_HOP  = 4'd1;
    localparam pos_t POS_TIME = 4'd2;     // bytes 2..9, lsb first
    localparam pos_t POS_SUM  = 4'd10;

    // ----------------------------------------------------------------------
    // opcodes
    // ----------------------------------------------------------------------

    typedef enum logic [7:0] {
        OP_SYNC    = 8'h10,     // nodes load their timers
        OP_MEASURE = 8'h20      // relay only
    } frame_op_e;

    // ----------------------------------------------------------------------
    // checksum
    // ----------------------------------------------------------------------

    // xor of bytes 0..9 starting from this seed
    localparam logic [7:0] SUM_SEED = 8'h00;

endpackage

/* frame_tx.sv */
`timescale 1ns/10ps

module frame_tx (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  ring_pkg::frame_op_e op,
    input  timer_pkg::time_t    stamp,
    output logic                tx_first,
    output logic                tx_last,
    output logic [7:0]          tx_data,
    output logic                tx_valid,
    output timer_pkg::time_t    sent_stamp
);
    import timer_pkg::*;
    import ring_pkg::*;

    logic       busy;
    logic       launch;
    pos_t       pos;        // next byte to drive
    time_t      stamp_q;
    logic [7:0] sum;
    logic [7:0] next_byte;

    assign launch     = start && !busy;   // a trigger mid-frame is dropped
    assign sent_stamp = stamp_q;

    always_comb begin
        if (pos == POS_HOP) begin
            next_byte = '0;     // master is hop 0
        end else if (pos < POS_SUM) begin
            next_byte = stamp_q[(pos - POS_TIME) * 8 +: 8];
        end else begin
            next_byte = sum;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            pos      <= POS_OP;
            tx_valid <= 1'b0;
            tx_first <= 1'b0;
            tx_last  <= 1'b0;
        end else begin
            tx_first <= 1'b0;
            tx_last  <= 1'b0;
            if (launch) begin
                busy     <= 1'b1;
                pos      <= POS_HOP;
                tx_valid <= 1'b1;
                tx_first <= 1'b1;
            end else if (busy) begin
                tx_valid <= 1'b1;
                tx_last  <= (pos == POS_SUM);
                pos      <= pos + 4'd1;
                if (pos == POS_SUM) busy <= 1'b0;
            end else begin
                tx_valid <= 1'b0;
            end
        end
    end

    // opcode goes straight out as payload byte 0
    always_ff @(posedge clk) begin
        if (launch) begin
            stamp_q <= stamp;
            tx_data <= op;
            sum     <= SUM_SEED ^ op;
        end else if (busy) begin
            tx_data <= next_byte;
            sum     <= sum ^ next_byte;
        end
    end

endmodule

/* frame_rx.sv */
`timescale 1ns/10ps

module frame_rx (
    input  logic        clk,
    input  logic        reset,
    input  logic        tx_start,
    input  logic        rx_first,
    input  logic        rx_last,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,
    output logic        frame_done,
    output logic        rx_error,
    output logic        lost,
    output logic [15:0] ring_delay
);
    import timer_pkg::*;
    import ring_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,       // frame out on the ring
        RECV        // frame coming back
    } state_e;

    state_e      state;
    logic [15:0] delay_cnt;
    pos_t        pos;
    logic [7:0]  sum;
    logic        bad;
    logic        op_bad;
    logic        byte_bad;
    logic        head;
    logic        frame_end;

    assign head = (state == WAIT) && rx_valid && rx_first;

    // ----------------------------------------------------------------------
    // per byte checks
    // ----------------------------------------------------------------------

    always_comb begin
        op_bad = !(rx_data == OP_SYNC || rx_data == OP_MEASURE) || rx_last;

        byte_bad = rx_first || (rx_last != (pos == POS_SUM));
        if (pos == POS_HOP && rx_data != HOP_WIDTH'(NODES)) byte_bad = 1'b1;
        if (pos == POS_SUM && rx_data != sum) byte_bad = 1'b1;

        frame_end = (state == RECV) && rx_valid && (rx_last || pos == POS_SUM);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            frame_done <= 1'b0;
            rx_error   <= 1'b0;
            lost       <= 1'b0;
            ring_delay <= '0;
        end else begin
            frame_done <= 1'b0;
            rx_error   <= 1'b0;
            lost       <= 1'b0;
            if (tx_start) begin
                lost  <= (state != IDLE);   // previous frame never came back
                state <= WAIT;
            end else if (head) begin
                state      <= RECV;
                ring_delay <= delay_cnt;
            end else if (frame_end) begin
                state      <= IDLE;
                frame_done <= 1'b1;
                rx_error   <= bad || byte_bad;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start) begin
            delay_cnt <= 16'd1;
        end else if (state == WAIT) begin
            delay_cnt <= delay_cnt + 16'd1;
        end

        if (head) begin
            pos <= POS_HOP;
            sum <= SUM_SEED ^ rx_data;
            bad <= op_bad;
        end else if (state == RECV && rx_valid) begin
            pos <= pos + 4'd1;
            sum <= sum ^ rx_data;
            bad <= bad || byte_bad;
        end
    end

endmodule

/* ring_node.sv */
`timescale 1ns/10ps

module ring_node (
    input  logic             clk,
    input  logic             reset,
    input  logic             rx_first,
    input  logic             rx_last,
    input  logic [7:0]       rx_data,
    input  logic             rx_valid,
    output logic             tx_first,
    output logic             tx_last,
    output logic [7:0]       tx_data,
    output logic             tx_valid,
    output timer_pkg::time_t local_time,
    output logic             synced
);
    import timer_pkg::*;
    import ring_pkg::*;

    pos_t                 pos;
    pos_t                 cur_pos;
    logic [HOP_WIDTH-1:0] hop_q;
    logic [7:0]           op_q;
    logic [7:0]           sum_q;
    time_t                stamp_q;
    logic [7:0]           out_byte;
    logic                 sync_end;

    assign cur_pos  = rx_first ? POS_OP : pos;
    assign sync_end = rx_valid && (cur_pos == POS_SUM) && (op_q == OP_SYNC);

    always_comb begin
        out_byte = rx_data;
        if (cur_pos == POS_HOP) begin
            out_byte = rx_data + 8'd1;
        end else if (cur_pos == POS_SUM) begin
            out_byte = rx_data ^ hop_q ^ (hop_q + 8'd1);   // patch for new hop
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pos        <= POS_OP;
            tx_valid   <= 1'b0;
            tx_first   <= 1'b0;
            tx_last    <= 1'b0;
            local_time <= '0;
            synced     <= 1'b0;
        end else begin
            tx_valid <= rx_valid;
            tx_first <= rx_valid && rx_first;
            tx_last  <= rx_valid && rx_last;
            if (rx_valid && cur_pos != 4'hf) pos <= cur_pos + 4'd1;
            // stamp was byte 0 time, we are hop + 10 later, +1 for this register
            if (sync_end && sum_q == rx_data) begin
                local_time <= stamp_q + time_t'(hop_q) + time_t'(FRAME_LEN);
            end else begin
                local_time <= local_time + 1'b1;
            end
            if (sync_end) synced <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // relay data and field capture
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        tx_data <= out_byte;
        if (rx_valid) begin
            sum_q <= (cur_pos == POS_OP) ? (SUM_SEED ^ rx_data) : (sum_q ^ rx_data);
            if (cur_pos == POS_OP) op_q <= rx_data;
            if (cur_pos == POS_HOP) hop_q <= rx_data;
            if (cur_pos >= POS_TIME && cur_pos < POS_SUM) begin
                stamp_q[(cur_pos - POS_TIME) * 8 +: 8] <= rx_data;
            end
        end
    end

endmodule

/* sync_master.sv */
`timescale 1ns/10ps

module sync_master (
    input  logic             clk,
    input  logic             reset,
    input  logic             force_renew,
    output timer_pkg::time_t master_time,
    output logic             tx_first,
    output logic             tx_last,
    output logic [7:0]       tx_data,
    output logic             tx_valid,
    input  logic             rx_first,
    input  logic             rx_last,
    input  logic [7:0]       rx_data,
    input  logic             rx_valid,
    output logic             frame_done,
    output logic             rx_error,
    output logic             lost,
    output logic [15:0]      ring_delay
);
    import timer_pkg::*;
    import ring_pkg::*;

    time_t       timer_q;
    logic [15:0] period_cnt;
    logic        trigger;
    logic        renew;
    frame_op_e   tx_op;
    time_t       sent_stamp;
    logic        tx_start;

    assign master_time = timer_q;
    assign tx_op       = renew ? OP_SYNC : OP_MEASURE;
    assign tx_start    = tx_valid && (timer_q == sent_stamp);  // byte 0 of the frame

    // ----------------------------------------------------------------------
    // timer, period and renew control
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_q    <= '0;
            period_cnt <= '0;
            trigger    <= 1'b0;
            renew      <= 1'b1;     // first frame is always sync
        end else begin
            timer_q <= timer_q + 1'b1;
            trigger <= (period_cnt == SYNC_PERIOD - 16'd1);
            if (period_cnt == SYNC_PERIOD - 16'd1) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + 16'd1;
            end
            if (force_renew) begin
                renew <= 1'b1;
            end else if (trigger) begin
                renew <= 1'b0;
            end
        end
    end

    frame_tx u_frame_tx (
        .clk        (clk),
        .reset      (reset),
        .start      (trigger),
        .op         (tx_op),
        .stamp      (timer_q + 1'b1),     // time when byte 0 leaves
        .tx_first   (tx_first),
        .tx_last    (tx_last),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .sent_stamp (sent_stamp)
    );

    frame_rx u_frame_rx (
        .clk        (clk),
        .reset      (reset),
        .tx_start   (tx_start),
        .rx_first   (rx_first),
        .rx_last    (rx_last),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .frame_done (frame_done),
        .rx_error   (rx_error),
        .lost       (lost),
        .ring_delay (ring_delay)
    );

endmodule

/* ring_top.sv */
`timescale 1ns/10ps

module ring_top (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    force_renew,
    output timer_pkg::time_t                        master_time,
    output timer_pkg::time_t [timer_pkg::NODES-1:0] node_time,
    output logic [timer_pkg::NODES-1:0]             node_synced,
    output logic                                    ring_tx_first,
    output logic                                    ring_tx_last,
    output logic [7:0]                              ring_tx_data,
    output logic                                    ring_tx_valid,
    input  logic                                    ring_rx_first,
    input  logic                                    ring_rx_last,
    input  logic [7:0]                              ring_rx_data,
    input  logic                                    ring_rx_valid,
    output logic                                    frame_done,
    output logic                                    rx_error,
    output logic                                    lost,
    output logic [15:0]                             ring_delay
);
    import timer_pkg::*;

    // link i feeds node i, link NODES leaves the chip
    logic [NODES:0]      link_first;
    logic [NODES:0]      link_last;
    logic [NODES:0][7:0] link_data;
    logic [NODES:0]      link_valid;

    sync_master u_sync_master (
        .clk         (clk),
        .reset       (reset),
        .force_renew (force_renew),
        .master_time (master_time),
        .tx_first    (link_first[0]),
        .tx_last     (link_last[0]),
        .tx_data     (link_data[0]),
        .tx_valid    (link_valid[0]),
        .rx_first    (ring_rx_first),
        .rx_last     (ring_rx_last),
        .rx_data     (ring_rx_data),
        .rx_valid    (ring_rx_valid),
        .frame_done  (frame_done),
        .rx_error    (rx_error),
        .lost        (lost),
        .ring_delay  (ring_delay)
    );

    for (genvar i = 0; i < NODES; i++) begin : g_node
        ring_node u_ring_node (
            .clk        (clk),
            .reset      (reset),
            .rx_first   (link_first[i]),
            .rx_last    (link_last[i]),
            .rx_data    (link_data[i]),
            .rx_valid   (link_valid[i]),
            .tx_first   (link_first[i+1]),
            .tx_last    (link_last[i+1]),
            .tx_data    (link_data[i+1]),
            .tx_valid   (link_valid[i+1]),
            .local_time (node_time[i]),
            .synced     (node_synced[i])
        );
    end

    assign ring_tx_first = link_first[NODES];
    assign ring_tx_last  = link_last[NODES];
    assign ring_tx_data  = link_data[NODES];
    assign ring_tx_valid = link_valid[NODES];

endmodule

/* tb_ring.sv */
`timescale 1ns/10ps

module tb_ring;
    import timer_pkg::*;
    import ring_pkg::*;

    localparam int PERIOD_CYCLES = int'(SYNC_PERIOD);
    localparam int WAIT_LIMIT    = PERIOD_CYCLES + 40;
    localparam int WATCHDOG_NS   = 12 * PERIOD_CYCLES * 4 + 400;

    logic              clk = 1'b0;
    logic              reset;
    logic              force_renew;
    time_t             master_time;
    time_t [NODES-1:0] node_time;
    logic [NODES-1:0]  node_synced;
    logic              ring_tx_first;
    logic              ring_tx_last;
    logic [7:0]        ring_tx_data;
    logic              ring_tx_valid;
    logic              ring_rx_first = 1'b0;
    logic              ring_rx_last = 1'b0;
    logic [7:0]        ring_rx_data = 8'h00;
    logic              ring_rx_valid = 1'b0;
    logic              frame_done;
    logic              rx_error;
    logic              lost;
    logic [15:0]       ring_delay;

    int          errors = 0;
    logic [31:0] rng_state = 32'hd812f8b4;
    time_t       exp_time;

    // frames are numbered in the order they come back
    int         ret_count = 0;
    pos_t       ret_pos = '0;
    int         corrupt_index = -1;
    int         drop_index = -1;
    pos_t       corrupt_pos = '0;
    logic [7:0] corrupt_mask = 8'h00;

    always #2 clk = ~clk;

    ring_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .force_renew   (force_renew),
        .master_time   (master_time),
        .node_time     (node_time),
        .node_synced   (node_synced),
        .ring_tx_first (ring_tx_first),
        .ring_tx_last  (ring_tx_last),
        .ring_tx_data  (ring_tx_data),
        .ring_tx_valid (ring_tx_valid),
        .ring_rx_first (ring_rx_first),
        .ring_rx_last  (ring_rx_last),
        .ring_rx_data  (ring_rx_data),
        .ring_rx_valid (ring_rx_valid),
        .frame_done    (frame_done),
        .rx_error      (rx_error),
        .lost          (lost),
        .ring_delay    (ring_delay)
    );

    // master timer model, zero at reset then one per cycle
    always @(posedge clk) begin
        if (reset) begin
            exp_time <= '0;
        end else begin
            exp_time <= exp_time + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // return cable
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        int   idx;
        pos_t cur_pos;
        #1;
        cur_pos = ring_tx_first ? 4'd0 : ret_pos;
        idx     = ring_tx_first ? ret_count : ret_count - 1;
        ring_rx_first = ring_tx_first;
        ring_rx_last  = ring_tx_last;
        ring_rx_valid = ring_tx_valid && (idx != drop_index);
        ring_rx_data  = ring_tx_data;
        if (ring_tx_valid && idx == corrupt_index && cur_pos == corrupt_pos) begin
            ring_rx_data = ring_tx_data ^ corrupt_mask;
        end
        if (ring_tx_valid) begin
            ret_pos = cur_pos + 4'd1;
            if (ring_tx_first) ret_count++;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------

    task automatic check_time(input string test, input time_t expected, input time_t actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", test, expected, actual);
        end
    endtask

    task automatic check_delay(input string test, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected delay %0d, actual %0d", test, expected, actual);
        end
    endtask

    task automatic check_flag(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", test, expected, actual);
        end
    endtask

    task automatic check_op(input string test, input frame_op_e expected,
                            input frame_op_e actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected op %02h, actual %02h", test, expected, actual);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic check_nodes_track_master(input string test);
        check_time(test, exp_time, master_time);
        for (int i = 0; i < NODES; i++) begin
            check_time(test, exp_time, node_time[i]);
        end
    endtask

    task automatic wait_frame_done(input string test);
        int n;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (frame_done !== 1'b1 && n < WAIT_LIMIT);
        if (frame_done !== 1'b1) begin
            errors++;
            $display("%s: frame_done did not arrive within %0d cycles", test, WAIT_LIMIT);
        end
    endtask

    task automatic check_clean_frame(input string test);
        wait_frame_done(test);
        check_flag(test, 1'b0, rx_error);
        check_delay(test, 16'(NODES), ring_delay);  // one register per node
    endtask

    // strobes of one frame on the ring output, starting at byte 0
    task automatic check_frame_strobes(input string test);
        check_flag(test, 1'b0, ring_tx_last);
        for (int b = 1; b < FRAME_LEN; b++) begin
            next_cycle();
            check_flag(test, 1'b1, ring_tx_valid);
            check_flag(test, 1'b0, ring_tx_first);
            check_flag(test, (b == FRAME_LEN - 1), ring_tx_last);
        end
    endtask

    task automatic check_next_op(input string test, input frame_op_e expected);
        int n;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (!(ring_tx_valid && ring_tx_first) && n < WAIT_LIMIT);
        if (ring_tx_valid && ring_tx_first) begin
            check_op(test, expected, frame_op_e'(ring_tx_data));
            check_frame_strobes(test);
        end else begin
            errors++;
            $display("%s: no frame seen on the ring output", test);
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------

    task automatic test_reset_quiet;
        for (int n = 1; n <= 150; n++) begin
            next_cycle();
            check_time("reset_quiet", time_t'(n), master_time);
            check_flag("reset_quiet", 1'b0, |node_synced);
            check_flag("reset_quiet", 1'b0, frame_done);
            check_flag("reset_quiet", 1'b0, rx_error);
            check_flag("reset_quiet", 1'b0, lost);
        end
    endtask

    task automatic test_first_sync;
        check_clean_frame("first_sync");
        for (int i = 0; i < NODES; i++) begin
            check_flag("first_sync", 1'b1, node_synced[i]);
        end
        repeat (5) begin
            repeat (7) next_cycle();
            check_nodes_track_master("first_sync");
        end
    endtask

    task automatic test_measure_frames;
        repeat (2) begin
            check_clean_frame("measure");
            check_nodes_track_master("measure");
        end
    endtask

    task automatic test_corrupt_byte;
        rng_state     = xorshift32(rng_state);
        corrupt_pos   = pos_t'(rng_state % 32'(FRAME_LEN));
        corrupt_mask  = (rng_state[15:8] == 8'h00) ? 8'h5a : rng_state[15:8];
        corrupt_index = ret_count;          // next frame to come back
        $display("corrupting byte %0d with mask %02h", corrupt_pos, corrupt_mask);
        wait_frame_done("corrupt");
        check_flag("corrupt", 1'b1, rx_error);
        check_clean_frame("corrupt_next");
    endtask

    task automatic test_drop_frame;
        int n;
        n = 0;
        drop_index = ret_count;
        do begin
            next_cycle();
            n++;
            if (lost !== 1'b1) check_flag("drop", 1'b0, frame_done);
        end while (lost !== 1'b1 && n < 2 * PERIOD_CYCLES + 40);
        if (lost !== 1'b1) begin
            errors++;
            $display("drop: no lost pulse after the dropped frame");
        end
        check_clean_frame("drop_next");
    endtask

    task automatic test_force_renew;
        force_renew = 1'b1;
        next_cycle();
        force_renew = 1'b0;
        check_next_op("renew_sync", OP_SYNC);
        check_clean_frame("renew_sync");
        check_next_op("renew_measure", OP_MEASURE);
        check_clean_frame("renew_measure");
        repeat (3) begin
            repeat (5) next_cycle();
            check_nodes_track_master("renew");
        end
    endtask

    initial begin
        reset       = 1'b1;
        force_renew = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_quiet();
        test_first_sync();
        test_measure_frames();
        test_corrupt_byte();
        test_drop_frame();
        test_force_renew();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("errors: %0d", errors);
        $display("Regression failed");
        $finish;
    end

endmodule

/* tb.f */
timer_pkg.sv
ring_pkg.sv
frame_tx.sv
frame_rx.sv
ring_node.sv
sync_master.sv
ring_top.sv
tb_ring.sv

/* run.sh */
#!/bin/sh
# build and run the ring testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_ring -o sim_ring
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_ring > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
